// File: c1_defines.svh
`ifndef C1_DEFINES_SVH
`define C1_DEFINES_SVH

// ========================================
// Bus and board widths
// ========================================

// Upper data lane seen by the glue chip
`define C1_DATA_BITS 8

// Player inputs, 8 joystick bits plus 2 extra buttons
`define C1_PLAYER_BITS 10

// ========================================
// Wait states
// ========================================

// Counter width, enough for the largest wait code
`define C1_WAIT_BITS 3

// Extra program ROM waits when nRomWait is low
`define C1_ROM_WAIT 1

// Card and system ROM waits on the CD system
`define C1_CARD_WAIT_CD 2

// Flops per synchronizer chain
`define C1_SYNC_STAGES 2

`endif

// File: c1_pkg.sv
`include "c1_defines.svh"

package c1_pkg;

	// ========================================
	// Top-level memory zones
	// ========================================

	// Selected by address bits 23..20
	typedef enum logic [3:0] {
		ROM,   // 000000~0FFFFF
		WRAM,  // 100000~1FFFFF
		PORT,  // 200000~2FFFFF
		IO,    // 300000~3FFFFF
		PAL,   // 400000~7FFFFF
		CARD,  // 800000~BFFFFF
		SROM,  // C00000~CFFFFF
		SRAM,  // D00000~DFFFFF
		NONE   // E00000~FFFFFF, unmapped
	} zoneT;

	// ========================================
	// Sound command latch
	// ========================================

	// Command byte from the 68k to the sound CPU
	// Pending stays set until the sound CPU clears it
	typedef struct packed {
		logic [`C1_DATA_BITS-1:0] cmd;
		logic                     pending;
	} soundLatchT;

endpackage

// File: c1Decode.sv
`timescale 1ns/1ns

module c1Decode (
	input  logic [23:17]     addr,
	input  logic             nAs,
	input  logic             nUds,
	input  logic             nLds,
	input  logic             rw,
	output c1_pkg::zoneT     zone,
	output logic             nIcomZone,
	output logic             nCtrl1Zone,
	output logic             nCtrl2Zone,
	output logic             nStatusBZone,
	output logic             nRomOeL,
	output logic             nRomOeU,
	output logic             nWrL,
	output logic             nWrU,
	output logic             nWwL,
	output logic             nWwU,
	output logic             nPortOeL,
	output logic             nPortOeU,
	output logic             nPortWeL,
	output logic             nPortWeU,
	output logic             nSromOeL,
	output logic             nSromOeU,
	output logic             nSramOeL,
	output logic             nSramOeU,
	output logic             nSramWeL,
	output logic             nSramWeU,
	output logic             nLspOe,
	output logic             nLspWe,
	output logic             nCrdo,
	output logic             nCrdw,
	output logic             nCrdc,
	output logic             nPortZone,
	output logic             nPalZone,
	output logic             nDipRd0,
	output logic             nDipRd1,
	output logic             nBitW0,
	output logic             nBitW1
);

	logic nRomZone, nWramZone, nIoZone, nC1RegsZone;
	logic nLspcZone, nCardZone, nSromZone, nSramZone;

	// ========================================
	// Top-level zones, all active low
	// ========================================
	assign nRomZone  = |{addr[23], addr[22], addr[21], addr[20]};
	assign nWramZone = |{addr[23], addr[22], addr[21], ~addr[20]};
	assign nPortZone = |{addr[23], addr[22], ~addr[21], addr[20]};
	assign nIoZone   = |{addr[23], addr[22], ~addr[21], ~addr[20]};
	// Palette needs at least one byte lane
	assign nPalZone  = |{addr[23], ~addr[22], nLds & nUds};
	assign nCardZone = |{~addr[23], addr[22]};
	assign nSromZone = |{~addr[23], ~addr[22], addr[21], addr[20]};
	assign nSramZone = |{~addr[23], ~addr[22], addr[21], ~addr[20]};

	// ========================================
	// IO sub-zones, split on bits 19..17
	// ========================================
	// Even bytes of the IO zone belong to the chip registers
	assign nC1RegsZone  = nUds | nIoZone;
	// 30xxxx read only
	assign nCtrl1Zone   = nC1RegsZone | ~rw | (|{addr[19], addr[18], addr[17]});
	// 32xxxx read/write, sound command and reply
	assign nIcomZone    = nC1RegsZone | (|{addr[19], addr[18], ~addr[17]});
	// 34xxxx read only
	assign nCtrl2Zone   = nC1RegsZone | ~rw | (|{addr[19], ~addr[18], addr[17]});
	// 38xxxx read only
	assign nStatusBZone = nC1RegsZone | ~rw | (|{~addr[19], addr[18], addr[17]});

	// Odd bytes, DIP reads and bit latches
	assign nDipRd0 = |{nIoZone, addr[19], addr[18], addr[17], ~rw, nLds};
	assign nDipRd1 = |{nIoZone, addr[19], addr[18], ~addr[17], ~rw, nLds};
	assign nBitW0  = |{nIoZone, ~addr[19], addr[18], addr[17], rw, nLds};
	assign nBitW1  = |{nIoZone, ~addr[19], addr[18], ~addr[17], rw, nLds};

	// Video controller at 3Cxxxx
	assign nLspcZone = |{nIoZone, ~addr[19], ~addr[18], addr[17]};

	// ========================================
	// Byte-lane strobes
	// ========================================
	assign nRomOeL  = ~rw | nLds | nRomZone;
	assign nRomOeU  = ~rw | nUds | nRomZone;
	assign nWrL     = ~rw | nLds | nWramZone;
	assign nWrU     = ~rw | nUds | nWramZone;
	assign nWwL     = rw | nLds | nWramZone;
	assign nWwU     = rw | nUds | nWramZone;
	assign nPortOeL = ~rw | nLds | nPortZone;
	assign nPortOeU = ~rw | nUds | nPortZone;
	assign nPortWeL = rw | nLds | nPortZone;
	assign nPortWeU = rw | nUds | nPortZone;
	assign nSromOeL = ~rw | nLds | nSromZone;
	assign nSromOeU = ~rw | nUds | nSromZone;
	assign nSramOeL = ~rw | nLds | nSramZone;
	assign nSramOeU = ~rw | nUds | nSramZone;
	assign nSramWeL = rw | nLds | nSramZone;
	assign nSramWeU = rw | nUds | nSramZone;
	// Video controller is word wide, upper lane qualifies
	assign nLspOe   = ~rw | nUds | nLspcZone;
	assign nLspWe   = rw | nUds | nLspcZone;
	// Memory card is byte wide on the lower lane
	assign nCrdo    = ~rw | nLds | nCardZone;
	assign nCrdw    = rw | nLds | nCardZone;
	assign nCrdc    = nCardZone | nAs;

	// Zone code for the wait logic, address only
	always_comb begin
		case (addr[23:22])
			2'b00:   zone = c1_pkg::zoneT'({2'b00, addr[21:20]});
			2'b01:   zone = c1_pkg::PAL;
			2'b10:   zone = c1_pkg::CARD;
			default: begin
				if (addr[21])
					zone = c1_pkg::NONE;
				else
					zone = addr[20] ? c1_pkg::SRAM : c1_pkg::SROM;
			end
		endcase
	end

endmodule

// File: c1Wait.sv
`timescale 1ns/1ns
`include "c1_defines.svh"

module c1Wait (
	input  logic         clk68k,
	input  logic         reset,
	input  logic         nAs,
	input  c1_pkg::zoneT zone,
	input  logic         systemCdx,
	input  logic         nRomWait,
	input  logic         nPWait0,
	input  logic         nPWait1,
	input  logic         pDtack,
	output logic         nDtack
);

	logic                     active;
	logic                     portCycle;
	logic                     curPort;
	logic                     startEdge;
	logic                     hold;
	logic [`C1_WAIT_BITS-1:0] count;
	logic [`C1_WAIT_BITS-1:0] target;
	logic [`C1_WAIT_BITS-1:0] zoneWaits;
	logic [`C1_WAIT_BITS-1:0] curTarget;
	logic [`C1_WAIT_BITS-1:0] nextCount;

	// ========================================
	// Wait count per zone
	// ========================================
	always_comb begin
		zoneWaits = '0;
		case (zone)
			c1_pkg::ROM:
				if (!nRomWait)
					zoneWaits = `C1_WAIT_BITS'(`C1_ROM_WAIT);
			// Cartridge sets its own code
			c1_pkg::PORT:
				zoneWaits = `C1_WAIT_BITS'({nPWait1, nPWait0});
			c1_pkg::CARD, c1_pkg::SROM:
				if (systemCdx)
					zoneWaits = `C1_WAIT_BITS'(`C1_CARD_WAIT_CD);
			default:
				zoneWaits = '0;
		endcase
	end

	// First edge with nAs low opens the cycle
	assign startEdge = !nAs && !active;
	// Live values on the start edge, held values after it
	assign curTarget = startEdge ? zoneWaits : target;
	assign curPort   = startEdge ? (zone == c1_pkg::PORT) : portCycle;
	// Cartridge back-pressure
	assign hold      = curPort && !pDtack;
	// Counter saturates at the target while stalled
	assign nextCount = startEdge ? '0 : ((count < curTarget) ? count + 1'b1 : count);

	always_ff @(posedge clk68k) begin
		if (reset) begin
			active    <= 1'b0;
			portCycle <= 1'b0;
			count     <= '0;
			target    <= '0;
			nDtack    <= 1'b1;
		end else if (nAs) begin
			// Strobe released, end of cycle
			active <= 1'b0;
			count  <= '0;
			nDtack <= 1'b1;
		end else begin
			active    <= 1'b1;
			count     <= nextCount;
			target    <= curTarget;
			portCycle <= curPort;
			if (nDtack && (nextCount == curTarget) && !hold)
				nDtack <= 1'b0;
		end
	end

endmodule

// File: c1Inputs.sv
`timescale 1ns/1ns
`include "c1_defines.svh"

module c1Inputs (
	input  logic                       clk68k,
	input  logic                       reset,
	input  logic [`C1_PLAYER_BITS-1:0] p1In,
	input  logic [`C1_PLAYER_BITS-1:0] p2In,
	input  logic                       nCd1,
	input  logic                       nCd2,
	input  logic                       nWp,
	input  logic                       systemMvs,
	input  logic                       nCtrl1Zone,
	input  logic                       nCtrl2Zone,
	input  logic                       nStatusBZone,
	output logic [`C1_DATA_BITS-1:0]   rdData,
	output logic                       rdOe
);

	localparam int RawBits = 2 * `C1_PLAYER_BITS + 4;

	logic [RawBits-1:0]         syncPipe [`C1_SYNC_STAGES];
	logic [`C1_PLAYER_BITS-1:0] p1Sync, p2Sync;
	logic                       nCd1Sync, nCd2Sync, nWpSync, mvsSync;

	// All board inputs share one chain
	always_ff @(posedge clk68k) begin
		if (reset) begin
			for (int i = 0; i < `C1_SYNC_STAGES; i++)
				syncPipe[i] <= '0;
		end else begin
			syncPipe[0] <= {systemMvs, nWp, nCd2, nCd1, p2In, p1In};
			for (int i = 1; i < `C1_SYNC_STAGES; i++)
				syncPipe[i] <= syncPipe[i-1];
		end
	end

	assign {mvsSync, nWpSync, nCd2Sync, nCd1Sync, p2Sync, p1Sync} =
		syncPipe[`C1_SYNC_STAGES-1];

	// Upper lane read mux, zones never overlap
	always_comb begin
		rdData = '0;
		if (!nCtrl1Zone)
			rdData = p1Sync[7:0];
		else if (!nCtrl2Zone)
			rdData = p2Sync[7:0];
		else if (!nStatusBZone)
			rdData = {mvsSync, nWpSync, nCd2Sync, nCd1Sync, p2Sync[9:8], p1Sync[9:8]};
	end

	assign rdOe = !nCtrl1Zone || !nCtrl2Zone || !nStatusBZone;

endmodule

// File: c1Regs.sv
`timescale 1ns/1ns
`include "c1_defines.svh"

module c1Regs (
	input  logic                     clk68k,
	input  logic                     reset,
	input  logic                     nIcomZone,
	input  logic                     rw,
	input  logic [`C1_DATA_BITS-1:0] dataIn,
	input  logic [`C1_DATA_BITS-1:0] sddWr,
	input  logic                     nSdz80R,
	input  logic                     nSdz80W,
	input  logic                     nSdz80Clr,
	output logic [`C1_DATA_BITS-1:0] rdData,
	output logic                     rdOe,
	output logic [`C1_DATA_BITS-1:0] sddRd,
	output logic                     nSdw
);

	c1_pkg::soundLatchT       cmdLatch;
	logic [`C1_DATA_BITS-1:0] reply;
	logic [`C1_DATA_BITS-1:0] dataHold;
	logic                     wrCond, wrSeen, wrGo, z80WSeen;

	// 68k write to the command zone
	assign wrCond = !nIcomZone && !rw;

	// Byte captured on the first write edge
	always_ff @(posedge clk68k)
		if (wrCond && !wrSeen)
			dataHold <= dataIn;

	always_ff @(posedge clk68k) begin
		if (reset) begin
			cmdLatch <= '0;
			reply    <= '0;
			wrSeen   <= 1'b0;
			wrGo     <= 1'b0;
			z80WSeen <= 1'b0;
			nSdw     <= 1'b1;
		end else begin
			wrSeen   <= wrCond;
			wrGo     <= wrCond && !wrSeen;
			// One-cycle pulse to the sound CPU
			nSdw     <= !wrGo;
			z80WSeen <= !nSdz80W;
			if (!nSdz80W && !z80WSeen)
				reply <= sddWr;
			// New command wins over a clear on the same edge
			if (wrGo) begin
				cmdLatch.cmd     <= dataHold;
				cmdLatch.pending <= 1'b1;
			end else if (!nSdz80Clr)
				cmdLatch <= '0;
		end
	end

	assign sddRd  = (!nSdz80R && cmdLatch.pending) ? cmdLatch.cmd : '0;
	// Reply back to the 68k in the same zone
	assign rdData = reply;
	assign rdOe   = !nIcomZone && rw;

endmodule

// File: neoC1.sv
`timescale 1ns/1ns
`include "c1_defines.svh"

module neoC1 (
	input  logic                       clk68k,
	input  logic                       reset,
	// 68k bus
	input  logic [23:17]               addr,
	input  logic                       nAs,
	input  logic                       nUds,
	input  logic                       nLds,
	input  logic                       rw,
	input  logic [`C1_DATA_BITS-1:0]   dataIn,
	output logic [`C1_DATA_BITS-1:0]   dataOut,
	output logic                       dataOe,
	output logic                       nDtack,
	// Wait requests
	input  logic                       nRomWait,
	input  logic                       nPWait0,
	input  logic                       nPWait1,
	input  logic                       pDtack,
	// Board inputs
	input  logic [`C1_PLAYER_BITS-1:0] p1In,
	input  logic [`C1_PLAYER_BITS-1:0] p2In,
	input  logic                       nCd1,
	input  logic                       nCd2,
	input  logic                       nWp,
	input  logic                       systemMvs,
	input  logic                       systemCdx,
	// Sound CPU
	input  logic [`C1_DATA_BITS-1:0]   sddWr,
	output logic [`C1_DATA_BITS-1:0]   sddRd,
	input  logic                       nSdz80R,
	input  logic                       nSdz80W,
	input  logic                       nSdz80Clr,
	output logic                       nSdw,
	// Memory strobes
	output logic nRomOeL, nRomOeU,
	output logic nWrL, nWrU, nWwL, nWwU,
	output logic nPortOeL, nPortOeU, nPortWeL, nPortWeU,
	output logic nPortZone,
	output logic nSromOeL, nSromOeU,
	output logic nSramOeL, nSramOeU, nSramWeL, nSramWeU,
	output logic nLspOe, nLspWe,
	output logic nCrdo, nCrdw, nCrdc,
	output logic nPalZone,
	output logic nDipRd0, nDipRd1,
	output logic nBitW0, nBitW1
);

	c1_pkg::zoneT             zone;
	logic                     nIcomZone, nCtrl1Zone, nCtrl2Zone, nStatusBZone;
	logic [`C1_DATA_BITS-1:0] inData, regsData;
	logic                     inOe, regsOe;

	c1Decode uDecode (
		.addr(addr), .nAs(nAs), .nUds(nUds), .nLds(nLds), .rw(rw),
		.zone(zone), .nIcomZone(nIcomZone), .nCtrl1Zone(nCtrl1Zone),
		.nCtrl2Zone(nCtrl2Zone), .nStatusBZone(nStatusBZone),
		.nRomOeL(nRomOeL), .nRomOeU(nRomOeU),
		.nWrL(nWrL), .nWrU(nWrU), .nWwL(nWwL), .nWwU(nWwU),
		.nPortOeL(nPortOeL), .nPortOeU(nPortOeU),
		.nPortWeL(nPortWeL), .nPortWeU(nPortWeU),
		.nSromOeL(nSromOeL), .nSromOeU(nSromOeU),
		.nSramOeL(nSramOeL), .nSramOeU(nSramOeU),
		.nSramWeL(nSramWeL), .nSramWeU(nSramWeU),
		.nLspOe(nLspOe), .nLspWe(nLspWe),
		.nCrdo(nCrdo), .nCrdw(nCrdw), .nCrdc(nCrdc),
		.nPortZone(nPortZone), .nPalZone(nPalZone),
		.nDipRd0(nDipRd0), .nDipRd1(nDipRd1), .nBitW0(nBitW0), .nBitW1(nBitW1)
	);

	c1Wait uWait (
		.clk68k(clk68k), .reset(reset), .nAs(nAs), .zone(zone),
		.systemCdx(systemCdx), .nRomWait(nRomWait), .nPWait0(nPWait0),
		.nPWait1(nPWait1), .pDtack(pDtack), .nDtack(nDtack)
	);

	c1Inputs uInputs (
		.clk68k(clk68k), .reset(reset), .p1In(p1In), .p2In(p2In),
		.nCd1(nCd1), .nCd2(nCd2), .nWp(nWp), .systemMvs(systemMvs),
		.nCtrl1Zone(nCtrl1Zone), .nCtrl2Zone(nCtrl2Zone),
		.nStatusBZone(nStatusBZone), .rdData(inData), .rdOe(inOe)
	);

	c1Regs uRegs (
		.clk68k(clk68k), .reset(reset), .nIcomZone(nIcomZone), .rw(rw),
		.dataIn(dataIn), .sddWr(sddWr), .nSdz80R(nSdz80R), .nSdz80W(nSdz80W),
		.nSdz80Clr(nSdz80Clr), .rdData(regsData), .rdOe(regsOe),
		.sddRd(sddRd), .nSdw(nSdw)
	);

	// Read sources are exclusive by decode
	assign dataOut = regsOe ? regsData : (inOe ? inData : '0);
	assign dataOe  = inOe | regsOe;

endmodule

// File: c1_chk.sv
`timescale 1ns/1ns

module c1_chk (
	input logic clk68k,
	input logic reset,
	input logic nAs,
	input logic nDtack,
	input logic nSdw,
	input logic inOe,
	input logic regsOe
);

	int failures = 0;

	// Acknowledge released one edge after the strobe goes high
	ackRelease: assert property (@(posedge clk68k) disable iff (reset) nAs |=> nDtack)
		else begin
			$error("nDtack still low one edge after nAs was released");
			failures++;
		end

	// Sound strobe is a single-cycle pulse
	sdwPulse: assert property (@(posedge clk68k) disable iff (reset) !nSdw |=> nSdw)
		else begin
			$error("nSdw held low for two cycles");
			failures++;
		end

	// Input mux and sound reply never drive together
	oneSource: assert property (@(posedge clk68k) disable iff (reset) !(inOe && regsOe))
		else begin
			$error("both read sources enabled at once");
			failures++;
		end

endmodule

// File: c1Monitor.sv
`timescale 1ns/1ns
`include "c1_defines.svh"

module c1Monitor (
	input logic                       clk68k, reset,
	input logic [23:17]               addr,
	input logic                       nAs, nUds, nLds, rw,
	input logic [`C1_DATA_BITS-1:0]   dataIn, sddWr, dataOut, sddRd,
	input logic                       nRomWait, nPWait0, nPWait1, pDtack, systemCdx,
	input logic [`C1_PLAYER_BITS-1:0] p1In, p2In,
	input logic                       nCd1, nCd2, nWp, systemMvs,
	input logic                       nSdz80R, nSdz80W, nSdz80Clr,
	input logic [26:0]                strobes,
	input c1_pkg::zoneT               zone,
	input logic                       nDtack, dataOe, nSdw
);

	int checks = 0;
	int errors = 0;

	// Model state
	logic                     mActive, mPort, expDtack, expNsdw;
	int                       mEdges, mTarget;
	logic                     wrSeen, wrGo, z80Seen;
	c1_pkg::soundLatchT       mLatch;
	logic [`C1_DATA_BITS-1:0] reply, dataHold;
	// Two stages of {mvs, nWp, nCd2, nCd1, p2[9:0], p1[9:0]}
	logic [23:0]              syncA, syncB;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// ========================================
	// Memory map table
	// ========================================
	function automatic logic [26:0] mapStrobes(input logic [6:0] a, input logic r, u, l, as);
		logic [3:0] top;
		logic [2:0] sub;
		logic       io, card, pal, rdU, rdL, wrU, wrL;
		top  = a[6:3];
		sub  = a[2:0];
		io   = top == 4'h3;
		card = top[3:2] == 2'b10;
		pal  = top[3:2] == 2'b01;
		rdU  = r && !u;
		rdL  = r && !l;
		wrU  = !r && !u;
		wrL  = !r && !l;
		return ~{top == 4'h0 && rdL, top == 4'h0 && rdU,
			top == 4'h1 && rdL, top == 4'h1 && rdU, top == 4'h1 && wrL, top == 4'h1 && wrU,
			top == 4'h2 && rdL, top == 4'h2 && rdU, top == 4'h2 && wrL, top == 4'h2 && wrU,
			top == 4'h2,
			top == 4'hC && rdL, top == 4'hC && rdU,
			top == 4'hD && rdL, top == 4'hD && rdU, top == 4'hD && wrL, top == 4'hD && wrU,
			io && sub == 3'd6 && rdU, io && sub == 3'd6 && wrU,
			card && rdL, card && wrL, card && !as,
			pal && (!u || !l),
			io && sub == 3'd0 && rdL, io && sub == 3'd1 && rdL,
			io && sub == 3'd4 && wrL, io && sub == 3'd5 && wrL};
	endfunction

	function automatic logic [3:0] mapZone(input logic [3:0] top);
		if (top < 4'h4)
			return top;
		else if (top < 4'h8)
			return c1_pkg::PAL;
		else if (top < 4'hC)
			return c1_pkg::CARD;
		else if (top == 4'hC)
			return c1_pkg::SROM;
		else if (top == 4'hD)
			return c1_pkg::SRAM;
		return c1_pkg::NONE;
	endfunction

	// ========================================
	// Reference model stepped on each rising edge
	// ========================================
	always @(posedge clk68k) begin
		logic       cond;
		logic [3:0] top;
		top  = addr[23:20];
		cond = top == 4'h3 && addr[19:17] == 3'd1 && !nUds && !rw;
		if (cond && !wrSeen)
			dataHold = dataIn;
		if (reset) begin
			mActive  = 1'b0;
			expDtack = 1'b1;
			{wrSeen, wrGo, z80Seen} = 3'b000;
			mLatch   = '0;
			reply    = '0;
			expNsdw  = 1'b1;
			syncA    = '0;
			syncB    = '0;
		end else begin
			syncB = syncA;
			syncA = {systemMvs, nWp, nCd2, nCd1, p2In, p1In};
			// Bus cycle timing
			if (nAs) begin
				mActive  = 1'b0;
				expDtack = 1'b1;
			end else begin
				if (!mActive) begin
					mActive = 1'b1;
					mEdges  = 0;
					mPort   = top == 4'h2;
					case (top)
						4'h0: mTarget = nRomWait ? 0 : `C1_ROM_WAIT;
						4'h2: mTarget = int'({nPWait1, nPWait0});
						4'h8, 4'h9, 4'hA, 4'hB, 4'hC: mTarget = systemCdx ? `C1_CARD_WAIT_CD : 0;
						default: mTarget = 0;
					endcase
				end else
					mEdges++;
				if (expDtack && mEdges >= mTarget && !(mPort && !pDtack))
					expDtack = 1'b0;
			end
			// Sound latches
			expNsdw = !wrGo;
			if (!nSdz80W && !z80Seen)
				reply = sddWr;
			z80Seen = !nSdz80W;
			if (wrGo) begin
				mLatch.cmd     = dataHold;
				mLatch.pending = 1'b1;
			end else if (!nSdz80Clr) begin
				mLatch = '0;
			end
			wrGo   = cond && !wrSeen;
			wrSeen = cond;
		end
	end

	// ========================================
	// Comparison at the falling edge with all outputs settled
	// ========================================
	always @(negedge clk68k) begin
		logic [2:0]               sub;
		logic                     regSel, ctrl1, ctrl2, statB, icomRd, expOe;
		logic [`C1_DATA_BITS-1:0] expData;
		sub    = addr[19:17];
		regSel = addr[23:20] == 4'h3 && !nUds && rw;
		ctrl1  = regSel && sub == 3'd0;
		icomRd = regSel && sub == 3'd1;
		ctrl2  = regSel && sub == 3'd2;
		statB  = regSel && sub == 3'd4;
		expOe  = ctrl1 || ctrl2 || statB || icomRd;
		if (icomRd)
			expData = reply;
		else if (ctrl1)
			expData = syncB[7:0];
		else if (ctrl2)
			expData = syncB[17:10];
		else
			expData = {syncB[23:20], syncB[19:18], syncB[9:8]};
		compare("strobes", 32'(strobes), 32'(mapStrobes(addr, rw, nUds, nLds, nAs)));
		compare("zone", 32'(zone), 32'(mapZone(addr[23:20])));
		compare("nDtack", 32'(nDtack), 32'(expDtack));
		compare("nSdw", 32'(nSdw), 32'(expNsdw));
		compare("dataOe", 32'(dataOe), 32'(expOe));
		if (expOe)
			compare("dataOut", 32'(dataOut), 32'(expData));
		compare("sddRd", 32'(sddRd), 32'((!nSdz80R && mLatch.pending) ? mLatch.cmd : 8'h00));
	end

endmodule

// File: tb_neoC1.sv
`timescale 1ns/1ns
`include "c1_defines.svh"

module tb_neoC1;

	localparam int NumCycles = 400;
	// Twelve edges per bus cycle plus margin for reset
	localparam int MaxCycles = NumCycles * 12 + 50;

	logic                       clk68k, reset;
	logic [23:17]               addr;
	logic                       nAs, nUds, nLds, rw;
	logic [`C1_DATA_BITS-1:0]   dataIn, dataOut, sddWr, sddRd;
	logic                       dataOe, nDtack, nSdw;
	logic                       nRomWait, nPWait0, nPWait1, pDtack;
	logic [`C1_PLAYER_BITS-1:0] p1In, p2In;
	logic                       nCd1, nCd2, nWp, systemMvs, systemCdx;
	logic                       nSdz80R, nSdz80W, nSdz80Clr;
	logic nRomOeL, nRomOeU, nWrL, nWrU, nWwL, nWwU;
	logic nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortZone;
	logic nSromOeL, nSromOeU, nSramOeL, nSramOeU, nSramWeL, nSramWeU;
	logic nLspOe, nLspWe, nCrdo, nCrdw, nCrdc, nPalZone;
	logic nDipRd0, nDipRd1, nBitW0, nBitW1;
	logic [26:0]                strobes;
	c1_pkg::zoneT               dutZone;
	integer                     seed;
	int                         cycles;
	int                         total;

	neoC1 i_dut (.*);

	// Strobes gathered in the monitor's table order
	assign strobes = {nRomOeL, nRomOeU, nWrL, nWrU, nWwL, nWwU,
		nPortOeL, nPortOeU, nPortWeL, nPortWeU, nPortZone,
		nSromOeL, nSromOeU, nSramOeL, nSramOeU, nSramWeL, nSramWeU,
		nLspOe, nLspWe, nCrdo, nCrdw, nCrdc, nPalZone,
		nDipRd0, nDipRd1, nBitW0, nBitW1};
	assign dutZone = i_dut.zone;

	c1Monitor i_mon (.zone(dutZone), .*);

	bind neoC1 c1_chk i_chk (.clk68k(clk68k), .reset(reset), .nAs(nAs),
		.nDtack(nDtack), .nSdw(nSdw), .inOe(inOe), .regsOe(regsOe));

	always #5 clk68k = ~clk68k;

	// ========================================
	// Run limit
	// ========================================
	always @(posedge clk68k) begin
		cycles <= cycles + 1;
		if (cycles >= MaxCycles) begin
			$display("Timeout after %0d cycles, a bus cycle never got nDtack", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Fresh sound CPU strobes and port back-pressure on every edge
	task automatic driveSideInputs();
		logic [31:0] r;
		r = $random(seed);
		sddWr     = r[7:0];
		nSdz80R   = r[8];
		nSdz80W   = |r[11:9];
		nSdz80Clr = |r[15:12];
		pDtack    = |r[17:16];
	endtask

	task automatic runBusCycle();
		logic [31:0] r;
		@(posedge clk68k);
		#1;
		r = $random(seed);
		// One cycle in eight hits the sound command zone and two hit the chip registers
		case (r[2:0])
			3'd0:       addr = 7'h19;
			3'd1, 3'd2: addr = {4'h3, r[5:3]};
			default:    addr = r[9:3];
		endcase
		rw        = r[10];
		nUds      = (r[2:0] == 3'd0) ? 1'b0 : (r[11] & r[12]);
		nLds      = r[13] & r[12];
		dataIn    = r[21:14];
		nRomWait  = r[22];
		nPWait0   = r[23];
		nPWait1   = r[24];
		systemCdx = r[25];
		r = $random(seed);
		p1In      = r[9:0];
		p2In      = r[19:10];
		nCd1      = r[20];
		nCd2      = r[21];
		nWp       = r[22];
		systemMvs = r[23];
		driveSideInputs();
		nAs = 1'b0;
		while (nDtack) begin
			@(posedge clk68k);
			#1;
			driveSideInputs();
		end
		nAs  = 1'b1;
		rw   = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
	endtask

	initial begin
		seed = 32'h64644835;
		cycles = 0;
		clk68k = 1'b0;
		reset = 1'b1;
		addr = '0;
		{nAs, nUds, nLds, rw} = 4'hF;
		dataIn = '0;
		{nRomWait, nPWait0, nPWait1, pDtack} = 4'hF;
		p1In = '0;
		p2In = '0;
		{nCd1, nCd2, nWp, systemMvs, systemCdx} = 5'b11100;
		sddWr = '0;
		{nSdz80R, nSdz80W, nSdz80Clr} = 3'b111;
		repeat (5) @(posedge clk68k);
		#1 reset = 1'b0;
		for (int i = 0; i < NumCycles; i++)
			runBusCycle();
		repeat (3) @(posedge clk68k);
		total = i_mon.errors + i_dut.i_chk.failures;
		$display("Checks %0d, monitor errors %0d, assertion errors %0d",
			i_mon.checks, i_mon.errors, i_dut.i_chk.failures);
		if (total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: files.f
+incdir+.
c1_pkg.sv
c1Decode.sv
c1Wait.sv
c1Inputs.sv
c1Regs.sv
neoC1.sv
c1_chk.sv
c1Monitor.sv
tb_neoC1.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_neoC1 -f files.f \
	&& ./obj_dir/Vtb_neoC1 +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TESTS PASSED$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
